//--- Bender.yml
package:
  name: redmule_vec

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/redmule_pkg.sv
      - rtl/redmule_stream_fifo.sv
      - rtl/redmule_scheduler.sv
      - rtl/redmule_pe.sv
      - rtl/redmule_z_buffer.sv
      - rtl/redmule_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/redmule_clk_gen.sv
      - testbench/redmule_tb.sv

//--- rtl/redmule_cfg.svh
/*
 * RedMulE configuration
 * Array size, element width, FIFO depths and tile count width
 */

`ifndef REDMULE_CFG_SVH
`define REDMULE_CFG_SVH

// Number of PEs, also the lane count of X, Y and Z vectors
`define ARRAY_WIDTH 4

// Beats per tile (K dimension)
`define ARRAY_HEIGHT 4

`define ELEM_BITS 16

`define IN_FIFO_DEPTH 4
`define Z_FIFO_DEPTH 2

`define TILE_CNT_BITS 8

`endif

//--- rtl/redmule_pe.sv
/*
 * RedMulE processing element
 * One wrapping multiply-accumulate lane, loaded with the bias on the first beat
 */

`default_nettype none

module redmule_pe (
  input  wire                clk_i,
  input  wire                rst_i,
  input  wire                op_valid_i,
  input  wire                op_first_i,
  input  wire                op_last_i,
  input  redmule_pkg::elem_t x_i,
  input  redmule_pkg::elem_t w_i,
  input  redmule_pkg::elem_t bias_i,
  output logic               res_valid_o,
  output redmule_pkg::elem_t res_o
);

  redmule_pkg::elem_t prod;
  redmule_pkg::elem_t acc_q;
  logic               res_valid_q;

  // Product truncated to element width
  assign prod = redmule_pkg::elem_t'(x_i * w_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= op_valid_i & op_last_i;
      if (op_valid_i) begin
        if (op_first_i) begin
          acc_q <= bias_i + prod;
        end else begin
          acc_q <= acc_q + prod;
        end
      end
    end
  end

  // Final sum is held in the accumulator until the next tile starts
  assign res_valid_o = res_valid_q;
  assign res_o       = acc_q;

endmodule

`default_nettype wire

//--- rtl/redmule_pkg.sv
/*
 * RedMulE package
 * Element, vector and counter types shared by the vector engine
 */

`default_nettype none

`include "redmule_cfg.svh"

package redmule_pkg;

  // Width of the beat index, at least one bit
  localparam int unsigned BEAT_BITS = (`ARRAY_HEIGHT > 1) ? $clog2(`ARRAY_HEIGHT) : 1;

  // One signed element, arithmetic wraps at ELEM_BITS
  typedef logic signed [`ELEM_BITS-1:0] elem_t;

  // One element per PE lane
  typedef elem_t [`ARRAY_WIDTH-1:0] vec_t;

  typedef logic [`TILE_CNT_BITS-1:0] tile_cnt_t;

  typedef logic [BEAT_BITS-1:0] beat_cnt_t;

endpackage

`default_nettype wire

//--- rtl/redmule_scheduler.sv
/*
 * RedMulE scheduler
 * Joins the X, W and Y streams into PE beats, counts beats and tiles,
 * and tracks job progress for busy and done
 */

`default_nettype none

`include "redmule_cfg.svh"

module redmule_scheduler (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   start_i,
  input  redmule_pkg::tile_cnt_t n_tiles_i,
  input  wire                   x_valid_i,
  input  redmule_pkg::vec_t     x_data_i,
  output logic                  x_ready_o,
  input  wire                   w_valid_i,
  input  redmule_pkg::elem_t    w_data_i,
  output logic                  w_ready_o,
  input  wire                   y_valid_i,
  input  redmule_pkg::vec_t     y_data_i,
  output logic                  y_ready_o,
  input  wire                   space_i,
  input  wire                   z_push_i,
  output logic                  op_valid_o,
  output logic                  op_first_o,
  output logic                  op_last_o,
  output redmule_pkg::vec_t     op_x_o,
  output redmule_pkg::elem_t    op_w_o,
  output redmule_pkg::vec_t     op_y_o,
  output logic                  busy_o,
  output logic                  done_o
);

  redmule_pkg::beat_cnt_t beat_q;
  redmule_pkg::tile_cnt_t n_tiles_q;
  redmule_pkg::tile_cnt_t issued_q;
  redmule_pkg::tile_cnt_t pushed_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   tiles_left;
  logic                   fire;

  assign op_first_o = (beat_q == '0);
  assign op_last_o  = (beat_q == redmule_pkg::beat_cnt_t'(`ARRAY_HEIGHT - 1));
  assign tiles_left = busy_q & (issued_q != n_tiles_q);

  // Y bias is only needed on the first beat of a tile
  assign fire = tiles_left & x_valid_i & w_valid_i & space_i &
                (~op_first_o | y_valid_i);

  assign x_ready_o = fire;
  assign w_ready_o = fire;
  assign y_ready_o = fire & op_first_o;

  // Operands go straight from the FIFO heads to the PE array
  assign op_valid_o = fire;
  assign op_x_o     = x_data_i;
  assign op_w_o     = w_data_i;
  assign op_y_o     = y_data_i;

  assign busy_o = busy_q;
  assign done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_q    <= '0;
      n_tiles_q <= '0;
      issued_q  <= '0;
      pushed_q  <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i && !busy_q) begin
        // New job, a start while busy is ignored
        busy_q    <= 1'b1;
        n_tiles_q <= n_tiles_i;
        issued_q  <= '0;
        pushed_q  <= '0;
        beat_q    <= '0;
      end else if (busy_q) begin
        if (fire) begin
          if (op_last_o) begin
            beat_q   <= '0;
            issued_q <= issued_q + 1'b1;
          end else begin
            beat_q <= beat_q + 1'b1;
          end
        end
        if (z_push_i) begin
          pushed_q <= pushed_q + 1'b1;
          // Last tile has left the Z buffer
          if (redmule_pkg::tile_cnt_t'(pushed_q + 1'b1) == n_tiles_q) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  a_start_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i && !busy_q |-> n_tiles_i != '0)
    else $error("Job started with a zero tile count");

endmodule

`default_nettype wire

//--- rtl/redmule_stream_fifo.sv
/*
 * RedMulE stream FIFO
 * Circular buffer between two valid/ready streams, any payload type
 */

`default_nettype none

module redmule_stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  wire      clk_i,
  input  wire      rst_i,
  input  wire      push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  wire      pop_ready_i,
  output payload_t pop_data_o
);

  localparam int unsigned PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_BITS = $clog2(DEPTH + 1);

  payload_t            mem_q [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                push;
  logic                pop;

  assign push_ready_o = (count_q != CNT_BITS'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // Storage has no reset, only the pointers do
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Pointers meet only when the buffer is empty or full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= CNT_BITS'(DEPTH) &&
    ((wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == CNT_BITS'(DEPTH))))
    else $error("FIFO occupancy and pointers disagree");

  // A stalled head entry must not change under the consumer
  a_pop_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o))
    else $error("FIFO pop data changed while stalled");

endmodule

`default_nettype wire

//--- rtl/redmule_top.sv
/*
 * RedMulE top level
 * Input FIFOs, scheduler, PE array and Z buffer of the integer vector engine
 */

`default_nettype none

`include "redmule_cfg.svh"

module redmule_top (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire                    start_i,
  input  redmule_pkg::tile_cnt_t n_tiles_i,
  output logic                   busy_o,
  output logic                   done_o,
  input  wire                    x_valid_i,
  output logic                   x_ready_o,
  input  redmule_pkg::vec_t      x_data_i,
  input  wire                    w_valid_i,
  output logic                   w_ready_o,
  input  redmule_pkg::elem_t     w_data_i,
  input  wire                    y_valid_i,
  output logic                   y_ready_o,
  input  redmule_pkg::vec_t      y_data_i,
  output logic                   z_valid_o,
  input  wire                    z_ready_i,
  output redmule_pkg::vec_t      z_data_o
);

  // FIFO heads towards the scheduler
  logic               x_fifo_valid, x_fifo_ready;
  logic               w_fifo_valid, w_fifo_ready;
  logic               y_fifo_valid, y_fifo_ready;
  redmule_pkg::vec_t  x_fifo_data;
  redmule_pkg::elem_t w_fifo_data;
  redmule_pkg::vec_t  y_fifo_data;

  // Broadcast operands
  logic               op_valid, op_first, op_last;
  redmule_pkg::vec_t  op_x;
  redmule_pkg::elem_t op_w;
  redmule_pkg::vec_t  op_y;

  // PE results and Z path
  logic [`ARRAY_WIDTH-1:0] res_valid;
  redmule_pkg::vec_t       res;
  logic                    space;
  logic                    z_push;
  logic                    zbuf_valid, zbuf_ready;
  redmule_pkg::vec_t       zbuf_data;

  redmule_stream_fifo #(
    .payload_t ( redmule_pkg::vec_t ),
    .DEPTH     ( `IN_FIFO_DEPTH     )
  ) i_x_fifo (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .push_valid_i ( x_valid_i    ),
    .push_ready_o ( x_ready_o    ),
    .push_data_i  ( x_data_i     ),
    .pop_valid_o  ( x_fifo_valid ),
    .pop_ready_i  ( x_fifo_ready ),
    .pop_data_o   ( x_fifo_data  )
  );

  redmule_stream_fifo #(
    .payload_t ( redmule_pkg::elem_t ),
    .DEPTH     ( `IN_FIFO_DEPTH      )
  ) i_w_fifo (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .push_valid_i ( w_valid_i    ),
    .push_ready_o ( w_ready_o    ),
    .push_data_i  ( w_data_i     ),
    .pop_valid_o  ( w_fifo_valid ),
    .pop_ready_i  ( w_fifo_ready ),
    .pop_data_o   ( w_fifo_data  )
  );

  redmule_stream_fifo #(
    .payload_t ( redmule_pkg::vec_t ),
    .DEPTH     ( `IN_FIFO_DEPTH     )
  ) i_y_fifo (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .push_valid_i ( y_valid_i    ),
    .push_ready_o ( y_ready_o    ),
    .push_data_i  ( y_data_i     ),
    .pop_valid_o  ( y_fifo_valid ),
    .pop_ready_i  ( y_fifo_ready ),
    .pop_data_o   ( y_fifo_data  )
  );

  redmule_scheduler i_scheduler (
    .clk_i      ( clk_i        ),
    .rst_i      ( rst_i        ),
    .start_i    ( start_i      ),
    .n_tiles_i  ( n_tiles_i    ),
    .x_valid_i  ( x_fifo_valid ),
    .x_data_i   ( x_fifo_data  ),
    .x_ready_o  ( x_fifo_ready ),
    .w_valid_i  ( w_fifo_valid ),
    .w_data_i   ( w_fifo_data  ),
    .w_ready_o  ( w_fifo_ready ),
    .y_valid_i  ( y_fifo_valid ),
    .y_data_i   ( y_fifo_data  ),
    .y_ready_o  ( y_fifo_ready ),
    .space_i    ( space        ),
    .z_push_i   ( z_push       ),
    .op_valid_o ( op_valid     ),
    .op_first_o ( op_first     ),
    .op_last_o  ( op_last      ),
    .op_x_o     ( op_x         ),
    .op_w_o     ( op_w         ),
    .op_y_o     ( op_y         ),
    .busy_o     ( busy_o       ),
    .done_o     ( done_o       )
  );

  // One PE per lane, W is shared by all of them
  for (genvar i = 0; i < `ARRAY_WIDTH; i++) begin : gen_pe
    redmule_pe i_pe (
      .clk_i       ( clk_i        ),
      .rst_i       ( rst_i        ),
      .op_valid_i  ( op_valid     ),
      .op_first_i  ( op_first     ),
      .op_last_i   ( op_last      ),
      .x_i         ( op_x[i]      ),
      .w_i         ( op_w         ),
      .bias_i      ( op_y[i]      ),
      .res_valid_o ( res_valid[i] ),
      .res_o       ( res[i]       )
    );
  end

  redmule_z_buffer i_z_buffer (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .res_valid_i  ( res_valid  ),
    .res_i        ( res        ),
    .space_o      ( space      ),
    .push_valid_o ( zbuf_valid ),
    .push_ready_i ( zbuf_ready ),
    .push_data_o  ( zbuf_data  ),
    .z_push_o     ( z_push     )
  );

  redmule_stream_fifo #(
    .payload_t ( redmule_pkg::vec_t ),
    .DEPTH     ( `Z_FIFO_DEPTH      )
  ) i_z_fifo (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .push_valid_i ( zbuf_valid ),
    .push_ready_o ( zbuf_ready ),
    .push_data_i  ( zbuf_data  ),
    .pop_valid_o  ( z_valid_o  ),
    .pop_ready_i  ( z_ready_i  ),
    .pop_data_o   ( z_data_o   )
  );

endmodule

`default_nettype wire

//--- rtl/redmule_z_buffer.sv
/*
 * RedMulE Z buffer
 * One-entry holding register between the PE array and the Z FIFO
 */

`default_nettype none

`include "redmule_cfg.svh"

module redmule_z_buffer (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire [`ARRAY_WIDTH-1:0]  res_valid_i,
  input  redmule_pkg::vec_t       res_i,
  output logic                    space_o,
  output logic                    push_valid_o,
  input  wire                     push_ready_i,
  output redmule_pkg::vec_t       push_data_o,
  output logic                    z_push_o
);

  redmule_pkg::vec_t data_q;
  logic              full_q;
  logic              capture;
  logic              push;

  // Capture once every lane has its result
  assign capture = &res_valid_i;
  assign push    = full_q & push_ready_i;

  // A result in flight from the PEs also claims the slot
  assign space_o = ~full_q & ~(|res_valid_i);

  assign push_valid_o = full_q;
  assign push_data_o  = data_q;
  assign z_push_o     = push;

  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= res_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (push) begin
      full_q <= 1'b0;
    end
  end

  a_lanes_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_i == '0) || (res_valid_i == '1))
    else $error("PE lanes finished out of step");

  a_no_capture_full: assert property (@(posedge clk_i) disable iff (rst_i)
    capture |-> !full_q)
    else $error("Z buffer captured a result while still holding one");

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/redmule_pkg.sv
rtl/redmule_stream_fifo.sv
rtl/redmule_scheduler.sv
rtl/redmule_pe.sv
rtl/redmule_z_buffer.sv
rtl/redmule_top.sv
testbench/redmule_clk_gen.sv
testbench/redmule_tb.sv

//--- testbench/redmule_clk_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock and a synchronous reset held for a few cycles
 */

`default_nettype none

module redmule_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5,
  parameter int RELEASE_DLY  = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset drops just after an edge, like the other inputs
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #RELEASE_DLY;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/redmule_tb.sv
/*
 * RedMulE testbench
 * Random X, W and Y streams into the vector engine, a model of Z = Y + X*W,
 * and concurrent checks on data, handshake and job completion
 */

`default_nettype none

`include "redmule_cfg.svh"

module redmule_tb;

  localparam int DRIVE_DLY    = 2;
  localparam int JOB1_TILES   = 1;
  localparam int JOB2_TILES   = 5;
  localparam int JOB3_TILES   = 6;
  localparam int TOTAL_TILES  = JOB1_TILES + JOB2_TILES + JOB3_TILES;
  localparam int DRAIN_CYCLES = 20;
  // Per tile budget leaves room for bubbles and back-pressure
  localparam int WATCHDOG_CYCLES = TOTAL_TILES * (`ARRAY_HEIGHT + 10) * 4 + 200;

  logic                   clk;
  logic                   rst;
  logic                   start;
  redmule_pkg::tile_cnt_t n_tiles;
  logic                   busy;
  logic                   done;
  logic                   x_valid;
  logic                   x_ready;
  redmule_pkg::vec_t      x_data;
  logic                   w_valid;
  logic                   w_ready;
  redmule_pkg::elem_t     w_data;
  logic                   y_valid;
  logic                   y_ready;
  redmule_pkg::vec_t      y_data;
  logic                   z_valid;
  logic                   z_ready;
  redmule_pkg::vec_t      z_data;

  // Stimulus of the current job and the expected Z vectors
  redmule_pkg::vec_t  x_mem [$];
  redmule_pkg::elem_t w_mem [$];
  redmule_pkg::vec_t  y_mem [$];
  redmule_pkg::vec_t  exp_q [$];
  redmule_pkg::vec_t  exp_head;
  int                 exp_count;

  integer seed;
  logic   bp_on;
  logic   job_check;
  int     value_errs;
  int     other_errs;
  int     pushed_total;
  int     done_total;
  int     exp_tiles_total;
  int     jobs_total;

  redmule_clk_gen #(
    .PERIOD       ( 40        ),
    .RESET_CYCLES ( 5         ),
    .RELEASE_DLY  ( DRIVE_DLY )
  ) u_clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  redmule_top u_redmule_top (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .start_i   ( start   ),
    .n_tiles_i ( n_tiles ),
    .busy_o    ( busy    ),
    .done_o    ( done    ),
    .x_valid_i ( x_valid ),
    .x_ready_o ( x_ready ),
    .x_data_i  ( x_data  ),
    .w_valid_i ( w_valid ),
    .w_ready_o ( w_ready ),
    .w_data_i  ( w_data  ),
    .y_valid_i ( y_valid ),
    .y_ready_o ( y_ready ),
    .y_data_i  ( y_data  ),
    .z_valid_o ( z_valid ),
    .z_ready_i ( z_ready ),
    .z_data_o  ( z_data  )
  );

  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic redmule_pkg::vec_t rand_vec();
    redmule_pkg::vec_t v;
    int i;
    for (i = 0; i < `ARRAY_WIDTH; i++) begin
      v[i] = redmule_pkg::elem_t'($random(seed));
    end
    return v;
  endfunction

  // Full-width sum per lane, reduced modulo 2^ELEM_BITS at the end
  function automatic redmule_pkg::vec_t model_tile(input int t);
    redmule_pkg::vec_t  z;
    redmule_pkg::elem_t xe;
    redmule_pkg::elem_t we;
    redmule_pkg::elem_t ye;
    longint             sum;
    int                 i;
    int                 k;
    for (i = 0; i < `ARRAY_WIDTH; i++) begin
      ye  = y_mem[t][i];
      sum = longint'(ye);
      for (k = 0; k < `ARRAY_HEIGHT; k++) begin
        xe  = x_mem[t * `ARRAY_HEIGHT + k][i];
        we  = w_mem[t * `ARRAY_HEIGHT + k];
        sum = sum + longint'(xe) * longint'(we);
      end
      z[i] = redmule_pkg::elem_t'(sum);
    end
    return z;
  endfunction

  task automatic refresh_head();
    exp_count = exp_q.size();
    if (exp_count != 0) begin
      exp_head = exp_q[0];
    end
  endtask

  task automatic build_job(input int tiles);
    int t;
    int b;
    x_mem.delete();
    w_mem.delete();
    y_mem.delete();
    for (t = 0; t < tiles; t++) begin
      y_mem.push_back(rand_vec());
      for (b = 0; b < `ARRAY_HEIGHT; b++) begin
        x_mem.push_back(rand_vec());
        w_mem.push_back(redmule_pkg::elem_t'($random(seed)));
      end
      exp_q.push_back(model_tile(t));
    end
    refresh_head();
    exp_tiles_total += tiles;
    jobs_total++;
  endtask

  // All three input streams from one process, pct is the chance of a valid
  task automatic drive_inputs(input int tiles, input int pct);
    int beats;
    int nx;
    int nw;
    int ny;
    bit tx;
    bit tw;
    bit ty;
    beats = tiles * `ARRAY_HEIGHT;
    nx    = 0;
    nw    = 0;
    ny    = 0;
    while (nx < beats || nw < beats || ny < tiles) begin
      if (!x_valid && nx < beats && chance(pct)) begin
        x_valid = 1'b1;
        x_data  = x_mem[nx];
      end
      if (!w_valid && nw < beats && chance(pct)) begin
        w_valid = 1'b1;
        w_data  = w_mem[nw];
      end
      if (!y_valid && ny < tiles && chance(pct)) begin
        y_valid = 1'b1;
        y_data  = y_mem[ny];
      end
      @(posedge clk);
      tx = x_valid && x_ready;
      tw = w_valid && w_ready;
      ty = y_valid && y_ready;
      #DRIVE_DLY;
      if (tx) begin
        x_valid = 1'b0;
        nx++;
      end
      if (tw) begin
        w_valid = 1'b0;
        nw++;
      end
      if (ty) begin
        y_valid = 1'b0;
        ny++;
      end
    end
  endtask

  task automatic run_job(input int tiles, input int pct, input bit bp, input bit restart);
    int wait_cnt;
    build_job(tiles);
    n_tiles = redmule_pkg::tile_cnt_t'(tiles);
    start   = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
    // A second start while busy must be ignored
    if (restart) begin
      n_tiles = redmule_pkg::tile_cnt_t'(3);
      start   = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      start = 1'b0;
    end
    bp_on = bp;
    drive_inputs(tiles, pct);
    do @(posedge clk); while (!done);
    #DRIVE_DLY;
    bp_on    = 1'b0;
    wait_cnt = 0;
    while (exp_count != 0 && wait_cnt < DRAIN_CYCLES) begin
      @(posedge clk);
      #DRIVE_DLY;
      wait_cnt++;
    end
    job_check = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    job_check = 1'b0;
  endtask

  // Random Z back-pressure while enabled
  always @(posedge clk) begin
    #DRIVE_DLY;
    z_ready = bp_on ? chance(50) : 1'b1;
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (z_valid && z_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        refresh_head();
      end
      if (u_redmule_top.z_push) begin
        pushed_total++;
      end
      if (done) begin
        done_total++;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) rst |=> !busy && !done && !z_valid)
    else begin
      other_errs++;
      $display("DUT not idle after reset: busy %b done %b z_valid %b",
               $sampled(busy), $sampled(done), $sampled(z_valid));
    end

  a_z_data: assert property (@(posedge clk) disable iff (rst)
    z_valid && z_ready && exp_count != 0 |-> z_data == exp_head)
    else begin
      value_errs++;
      $display("** Error: z_data_o expected %h got %h", $sampled(exp_head), $sampled(z_data));
    end

  a_z_expected: assert property (@(posedge clk) disable iff (rst)
    z_valid && z_ready |-> exp_count != 0)
    else begin
      other_errs++;
      $display("Z vector delivered while no result was expected");
    end

  a_z_held: assert property (@(posedge clk) disable iff (rst)
    z_valid && !z_ready |=> z_valid)
    else begin
      other_errs++;
      $display("Z valid dropped before its transfer");
    end

  a_z_stable: assert property (@(posedge clk) disable iff (rst)
    z_valid && !z_ready |=> $stable(z_data))
    else begin
      value_errs++;
      $display("** Error: z_data_o changed to %h while stalled", $sampled(z_data));
    end

  a_done_on_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
    else begin
      other_errs++;
      $display("Busy fell without a done pulse");
    end

  a_fall_on_done: assert property (@(posedge clk) disable iff (rst) done |-> $fell(busy))
    else begin
      other_errs++;
      $display("Done pulsed outside the cycle where busy fell");
    end

  a_done_pushes: assert property (@(posedge clk) disable iff (rst)
    done |-> pushed_total == exp_tiles_total)
    else begin
      value_errs++;
      $display("** Error: Z buffer pushes at done_o expected %h got %h",
               $sampled(exp_tiles_total), $sampled(pushed_total));
    end

  a_drained: assert property (@(posedge clk) disable iff (rst) job_check |-> exp_count == 0)
    else begin
      other_errs++;
      $display("Z results missing at end of job, %0d still expected", $sampled(exp_count));
    end

  a_done_count: assert property (@(posedge clk) disable iff (rst)
    job_check |-> done_total == jobs_total)
    else begin
      value_errs++;
      $display("** Error: done_o pulses expected %h got %h",
               $sampled(jobs_total), $sampled(done_total));
    end

  a_idle_at_end: assert property (@(posedge clk) disable iff (rst) job_check |-> !busy)
    else begin
      other_errs++;
      $display("Busy still high after the job finished");
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d Z results outstanding",
             WATCHDOG_CYCLES, exp_count);
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    $display("Test failures found");
    $finish;
  end

  initial begin
    seed            = 5;
    start           = 1'b0;
    n_tiles         = '0;
    x_valid         = 1'b0;
    x_data          = '0;
    w_valid         = 1'b0;
    w_data          = '0;
    y_valid         = 1'b0;
    y_data          = '0;
    z_ready         = 1'b1;
    bp_on           = 1'b0;
    job_check       = 1'b0;
    exp_head        = '0;
    exp_count       = 0;
    value_errs      = 0;
    other_errs      = 0;
    pushed_total    = 0;
    done_total      = 0;
    exp_tiles_total = 0;
    jobs_total      = 0;
    do @(posedge clk); while (rst);
    #DRIVE_DLY;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;

    // Single tile without bubbles
    run_job(JOB1_TILES, 100, 1'b0, 1'b0);
    // Several tiles with random input gaps
    run_job(JOB2_TILES, 50, 1'b0, 1'b0);
    // Back-pressure on Z and a start while busy
    run_job(JOB3_TILES, 80, 1'b1, 1'b1);

    repeat (4) @(posedge clk);
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
